/* tlb_l2.f */
+incdir+logic
logic/tlb_pkg.sv
logic/tlb_ram.sv
logic/tlb_va_block.sv
logic/tlb_search_ctrl.sv
logic/tlb_result.sv
logic/tlb_l2.sv
verif/tlb_l2_checker.sv
verif/tlb_l2_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tlb_l2_tb
FILELIST  ?= tlb_l2.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tlb_l2_tb.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_l2_tb;

   localparam int         RES_WAIT  = `TLB_OFFSETS + 4;
   localparam int         IDLE_WAIT = 32;
   localparam logic [2:0] RES_HIT   = 3'b100;   // {hit, miss, prot}
   localparam logic [2:0] RES_MISS  = 3'b010;
   localparam logic [2:0] RES_PROT  = 3'b001;

   logic                    clk_i;
   logic                    rst_ni;
   tlb_pkg::lookup_req_t    req;
   tlb_pkg::cfg_wr_t        cfg;
   logic                    trans_sent;
   tlb_pkg::tlb_result_t    result;
   logic                    busy;
   logic [`TLB_ADDR_W-1:0]  paddr;
   int                      errors;
   int                      checks;
   int                      seed;

   // Reference copy of the TLB contents
   logic [`TLB_VPN_W-1:0]   m_start [`TLB_BLOCKS][`TLB_SETS][`TLB_OFFSETS];
   logic [`TLB_VPN_W-1:0]   m_end   [`TLB_BLOCKS][`TLB_SETS][`TLB_OFFSETS];
   logic                    m_valid [`TLB_BLOCKS][`TLB_SETS][`TLB_OFFSETS];
   logic                    m_wok   [`TLB_BLOCKS][`TLB_SETS][`TLB_OFFSETS];
   logic [`TLB_VPN_W-1:0]   m_pa    [`TLB_SETS][`TLB_OFFSETS][`TLB_BLOCKS];

   tlb_l2 dut0 (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (req),
      .cfg_i        (cfg),
      .trans_sent_i (trans_sent),
      .result_o     (result),
      .busy_o       (busy),
      .paddr_o      (paddr)
   );

   bind tlb_l2 tlb_l2_checker chk0 (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .result_i (result_o),
      .busy_i   (busy_o),
      .paddr_i  (paddr_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Bus drivers enter and leave 1 ns after a clock edge
   ////////////////////////////////////////////////////////////
   task automatic write_cfg(input logic [8:0] addr, input logic [30:0] data);
      cfg.en   = 1'b1;
      cfg.addr = addr;
      cfg.data = data;
      @(posedge clk_i);
      #1;
      cfg.en = 1'b0;
   endtask

   task automatic load_entry(input logic [1:0] blk, input logic [2:0] set, input logic [1:0] off,
                             input logic [19:0] lo, input logic [19:0] hi, input logic wok,
                             input logic [19:0] ppn);
      write_cfg({1'b0, set, 1'b0, off, blk}, {1'b1, wok, 9'd0, lo});   // Start word
      write_cfg({1'b0, set, 1'b1, off, blk}, {1'b1, wok, 9'd0, hi});   // End word
      write_cfg({1'b1, set, 1'b0, off, blk}, {11'd0, ppn});
      m_start[blk][set][off] = lo;
      m_end[blk][set][off]   = hi;
      m_valid[blk][set][off] = 1'b1;
      m_wok[blk][set][off]   = wok;
      m_pa[set][off][blk]    = ppn;
   endtask

   task automatic clear_entries();
      for (int b = 0; b < `TLB_BLOCKS; b++) begin
         for (int s = 0; s < `TLB_SETS; s++) begin
            for (int o = 0; o < `TLB_OFFSETS; o++) begin
               write_cfg({1'b0, 3'(s), 1'b0, 2'(o), 2'(b)}, 31'd0);
               m_valid[b][s][o] = 1'b0;
            end
         end
      end
   endtask

   function automatic logic [31:0] make_vaddr(input logic [19:0] vpn);
      logic [31:0] r;
      r = $random(seed);
      return {vpn, r[11:0]};   // Random page offset
   endfunction

   // First match by offset and then by block
   task automatic predict(input logic [31:0] vaddr, input logic is_write,
                          output logic [2:0] exp_res, output logic [31:0] exp_pa);
      logic [19:0] vpn;
      logic [2:0]  s;
      logic        found;
      vpn     = vaddr[31:12];
      s       = vpn[2:0];
      found   = 1'b0;
      exp_res = RES_MISS;
      exp_pa  = '0;
      for (int o = 0; o < `TLB_OFFSETS; o++) begin
         for (int b = 0; b < `TLB_BLOCKS; b++) begin
            if (!found && m_valid[b][s][o] && m_start[b][s][o] <= vpn &&
                vpn <= m_end[b][s][o]) begin
               found   = 1'b1;
               exp_res = (is_write && !m_wok[b][s][o]) ? RES_PROT : RES_HIT;
               exp_pa  = {m_pa[s][o][b], vaddr[11:0]};
            end
         end
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < IDLE_WAIT) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (busy) begin
         $display("Timeout: DUT still busy after %0d cycles", IDLE_WAIT);
         errors++;
      end
   endtask

   task automatic wait_result(output logic [2:0] got);
      int n;
      n = 0;
      while (result == '0 && n < RES_WAIT) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (result == '0) begin
         $display("Timeout: no lookup result within %0d cycles", RES_WAIT);
         errors++;
      end
      got = result;
   endtask

   task automatic send_trans();
      trans_sent = 1'b1;
      @(posedge clk_i);
      #1;
      trans_sent = 1'b0;
      check_value("busy after trans_sent", {31'd0, busy}, 32'd0);
   endtask

   task automatic do_lookup(input logic [31:0] vaddr, input logic is_write, input logic send_done);
      logic [2:0]  exp_res;
      logic [2:0]  got;
      logic [31:0] exp_pa;
      predict(vaddr, is_write, exp_res, exp_pa);
      wait_idle();
      req.valid    = 1'b1;
      req.vaddr    = vaddr;
      req.is_write = is_write;
      @(posedge clk_i);
      #1;
      req.valid = 1'b0;
      check_value("busy after request", {31'd0, busy}, 32'd1);
      wait_result(got);
      check_value("outcome", {29'd0, got}, {29'd0, exp_res});
      if (exp_res == RES_HIT) begin
         check_value("paddr", paddr, exp_pa);
      end
      @(posedge clk_i);
      #1;
      check_value("outcome after pulse", {29'd0, result}, 32'd0);   // Single pulse
      check_value("busy after outcome", {31'd0, busy}, {31'd0, exp_res == RES_HIT});
      if (exp_res == RES_HIT && send_done) begin
         send_trans();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////
   task automatic reset_and_empty();
      check_value("busy after reset", {31'd0, busy}, 32'd0);
      check_value("result after reset", {29'd0, result}, 32'd0);
      do_lookup(make_vaddr(20'h12345), 1'b0, 1'b1);
   endtask

   task automatic range_hits();
      clear_entries();
      load_entry(2'd1, 3'd3, 2'd2, 20'h00103, 20'h0010B, 1'b1, 20'hA1103);
      load_entry(2'd2, 3'd5, 2'd0, 20'h40005, 20'h40005, 1'b1, 20'hB2005);
      load_entry(2'd3, 3'd0, 2'd3, 20'h80000, 20'h80100, 1'b1, 20'hC3000);
      load_entry(2'd0, 3'd7, 2'd1, 20'h0000F, 20'h0001F, 1'b1, 20'hD400F);
      do_lookup(make_vaddr(20'h00103), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h0010B), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h000FB), 1'b0, 1'b1);   // Just below
      do_lookup(make_vaddr(20'h00113), 1'b0, 1'b1);   // Just above
      do_lookup(make_vaddr(20'h40005), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h3FFFD), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h4000D), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h80080), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h80100), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h80108), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h00017), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h00027), 1'b0, 1'b1);
   endtask

   task automatic write_protect();
      clear_entries();
      load_entry(2'd0, 3'd6, 2'd1, 20'h20006, 20'h20016, 1'b0, 20'hE5006);
      load_entry(2'd2, 3'd6, 2'd0, 20'h30006, 20'h3000E, 1'b1, 20'hF6000);
      do_lookup(make_vaddr(20'h20016), 1'b1, 1'b1);   // Write to a read-only page
      do_lookup(make_vaddr(20'h20016), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h3000E), 1'b1, 1'b1);
   endtask

   task automatic overlap_priority();
      clear_entries();
      load_entry(2'd0, 3'd2, 2'd2, 20'h5000A, 20'h5007A, 1'b1, 20'h11111);
      load_entry(2'd3, 3'd2, 2'd1, 20'h5000A, 20'h5007A, 1'b1, 20'h22222);
      do_lookup(make_vaddr(20'h5002A), 1'b0, 1'b1);
      check_value("winner page", {12'd0, paddr[31:12]}, 32'h22222);   // Lower offset wins
      load_entry(2'd2, 3'd2, 2'd0, 20'h50002, 20'h50032, 1'b1, 20'h33333);
      load_entry(2'd1, 3'd2, 2'd0, 20'h5001A, 20'h5004A, 1'b1, 20'h44444);
      do_lookup(make_vaddr(20'h5002A), 1'b0, 1'b1);
      check_value("winner page", {12'd0, paddr[31:12]}, 32'h44444);   // Lower block wins
      do_lookup(make_vaddr(20'h5000A), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h5005A), 1'b0, 1'b1);
   endtask

   task automatic busy_backpressure();
      logic [31:0] hit_va;
      logic [31:0] held_pa;
      logic [2:0]  held_res;
      clear_entries();
      load_entry(2'd1, 3'd4, 2'd0, 20'h60004, 20'h60004, 1'b1, 20'h55555);
      hit_va = make_vaddr(20'h60004);
      predict(hit_va, 1'b0, held_res, held_pa);
      do_lookup(hit_va, 1'b0, 1'b0);
      req.valid    = 1'b1;                            // Must be ignored
      req.vaddr    = make_vaddr(20'h6000C);
      req.is_write = 1'b0;
      @(posedge clk_i);
      #1;
      req.valid = 1'b0;
      for (int i = 0; i < RES_WAIT; i++) begin
         @(posedge clk_i);
         #1;
         check_value("result while held", {29'd0, result}, 32'd0);
         check_value("busy while held", {31'd0, busy}, 32'd1);
         check_value("paddr while held", paddr, held_pa);
      end
      send_trans();
      do_lookup(make_vaddr(20'h6000C), 1'b0, 1'b1);
      do_lookup(make_vaddr(20'h60004), 1'b1, 1'b1);
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s finished with %0d mismatches", name, errors - errors_before);
   endtask

   initial begin
      int e0;
      errors     = 0;
      checks     = 0;
      seed       = 32'h3d60_2065;
      rst_ni     = 1'b0;
      req        = '0;
      cfg        = '0;
      trans_sent = 1'b0;
      for (int b = 0; b < `TLB_BLOCKS; b++) begin
         for (int s = 0; s < `TLB_SETS; s++) begin
            for (int o = 0; o < `TLB_OFFSETS; o++) begin
               m_valid[b][s][o] = 1'b0;
            end
         end
      end
      repeat (2) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
      e0 = errors;
      reset_and_empty();
      report_test("reset_and_empty", e0);
      e0 = errors;
      range_hits();
      report_test("range_hits", e0);
      e0 = errors;
      write_protect();
      report_test("write_protect", e0);
      e0 = errors;
      overlap_priority();
      report_test("overlap_priority", e0);
      e0 = errors;
      busy_backpressure();
      report_test("busy_backpressure", e0);
      $display("Checks run: %0d, mismatches: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Run time limit
   initial begin
      #100us;
      $display("Simulation time limit reached before the tests finished");
      $display("Test failed");
      $finish;
   end

endmodule

/* verif/tlb_l2_checker.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_l2_checker (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  tlb_pkg::tlb_result_t    result_i,
   input  logic                    busy_i,
   input  logic [`TLB_ADDR_W-1:0]  paddr_i
);

   logic [2:0] res_bits;
   logic       hit_hold_q;   // A hit was reported in this lookup

   assign res_bits = {result_i.hit, result_i.miss, result_i.prot};

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_hold_q <= 1'b0;
      end else if (result_i.hit) begin
         hit_hold_q <= 1'b1;
      end else if (!busy_i) begin
         hit_hold_q <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Outcome rules
   ////////////////////////////////////////////////////////////
   a_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(res_bits))
      else $error("result_o has more than one outcome bit set");

   a_result_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (|res_bits) |-> busy_i)
      else $error("result_o pulsed while busy_o was low");

   // Translation held until the requester takes it
   a_paddr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (hit_hold_q && busy_i) |-> $stable(paddr_i))
      else $error("paddr_o changed while a hit was pending");

endmodule

/* logic/tlb_l2.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_l2 (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  tlb_pkg::lookup_req_t    req_i,
   input  tlb_pkg::cfg_wr_t        cfg_i,
   input  logic                    trans_sent_i,
   output tlb_pkg::tlb_result_t    result_o,
   output logic                    busy_o,
   output logic [`TLB_ADDR_W-1:0]  paddr_o
);

   logic                                cfg_pa;
   logic [`TLB_BLOCKS-1:0]              va_we;
   logic [`TLB_VA_AW-1:0]               va_waddr;
   tlb_pkg::tlb_entry_t                 va_wdata;
   logic                                pa_we;
   logic [`TLB_PA_AW-1:0]               pa_waddr;
   logic [`TLB_ADDR_W-1:0]              vaddr;
   logic                                is_write;
   logic [`TLB_SET_W-1:0]               set;
   logic [`TLB_OFF_W-1:0]               off;
   logic                                probe_valid;
   logic                                probe_last;
   logic                                stop;
   logic                                rel;
   tlb_pkg::probe_t [`TLB_BLOCKS-1:0]   probes;

   ////////////////////////////////////////////////////////////
   // Configuration write decode
   ////////////////////////////////////////////////////////////
   assign cfg_pa   = cfg_i.addr[`TLB_CFG_PA_BIT];
   assign va_waddr = cfg_i.addr[`TLB_CFG_PA_BIT-1:`TLB_BLK_W];  // {set, half, offset}
   assign pa_we    = cfg_i.en && cfg_pa;
   assign pa_waddr = {cfg_i.addr[`TLB_CFG_PA_BIT-1 -: `TLB_SET_W],
                      cfg_i.addr[`TLB_CFG_HALF_BIT-1:0]};

   assign va_wdata.valid    = cfg_i.data[`TLB_CFG_VALID_BIT];
   assign va_wdata.write_ok = cfg_i.data[`TLB_CFG_WOK_BIT];
   assign va_wdata.spare    = '0;
   assign va_wdata.vpn      = cfg_i.data[`TLB_VPN_W-1:0];

   tlb_search_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (req_i),
      .stop_i        (stop),
      .release_i     (rel),
      .vaddr_o       (vaddr),
      .is_write_o    (is_write),
      .set_o         (set),
      .off_o         (off),
      .probe_valid_o (probe_valid),
      .probe_last_o  (probe_last),
      .busy_o        (busy_o)
   );

   for (genvar g = 0; g < `TLB_BLOCKS; g++) begin : g_blk
      // Block index sits in the low address bits
      assign va_we[g] = cfg_i.en && !cfg_pa && (cfg_i.addr[`TLB_BLK_W-1:0] == `TLB_BLK_W'(g));

      tlb_va_block u_va_block (
         .clk_i      (clk_i),
         .rst_ni     (rst_ni),
         .we_i       (va_we[g]),
         .waddr_i    (va_waddr),
         .wdata_i    (va_wdata),
         .set_i      (set),
         .off_i      (off),
         .vpn_i      (vaddr[`TLB_PAGE_W +: `TLB_VPN_W]),
         .is_write_i (is_write),
         .probe_o    (probes[g])
      );
   end

   tlb_result u_result (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .probes_i      (probes),
      .probe_valid_i (probe_valid),
      .probe_last_i  (probe_last),
      .set_i         (set),
      .off_i         (off),
      .page_off_i    (vaddr[`TLB_PAGE_W-1:0]),
      .pa_we_i       (pa_we),
      .pa_waddr_i    (pa_waddr),
      .pa_wdata_i    (cfg_i.data[`TLB_VPN_W-1:0]),
      .trans_sent_i  (trans_sent_i),
      .stop_o        (stop),
      .release_o     (rel),
      .result_o      (result_o),
      .paddr_o       (paddr_o)
   );

endmodule

/* logic/tlb_result.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_result (
   input  logic                               clk_i,
   input  logic                               rst_ni,
   input  tlb_pkg::probe_t [`TLB_BLOCKS-1:0]  probes_i,
   input  logic                               probe_valid_i,
   input  logic                               probe_last_i,
   input  logic [`TLB_SET_W-1:0]              set_i,
   input  logic [`TLB_OFF_W-1:0]              off_i,
   input  logic [`TLB_PAGE_W-1:0]             page_off_i,
   input  logic                               pa_we_i,
   input  logic [`TLB_PA_AW-1:0]              pa_waddr_i,
   input  logic [`TLB_VPN_W-1:0]              pa_wdata_i,
   input  logic                               trans_sent_i,
   output logic                               stop_o,
   output logic                               release_o,
   output tlb_pkg::tlb_result_t               result_o,
   output logic [`TLB_ADDR_W-1:0]             paddr_o
);

   logic [`TLB_OFF_W-1:0]  off_q;
   logic                   any_hit;
   logic                   win_prot;
   logic [`TLB_BLK_W-1:0]  win_blk;
   logic                   decide;
   logic                   decided_q;   // Outcome known for this lookup
   logic                   hit_wait_q;
   logic [`TLB_PA_AW-1:0]  pa_raddr;
   logic [`TLB_VPN_W-1:0]  pa_rdata;
   tlb_pkg::tlb_result_t   pend_q;

   // Offset of the probe whose result is present now
   always_ff @(posedge clk_i) begin
      off_q <= off_i;
   end

   // Lowest matching block wins, scan runs downward
   always_comb begin
      any_hit  = 1'b0;
      win_prot = 1'b0;
      win_blk  = '0;
      for (int b = `TLB_BLOCKS - 1; b >= 0; b--) begin
         if (probes_i[b].hit) begin
            any_hit  = 1'b1;
            win_prot = probes_i[b].prot;
            win_blk  = `TLB_BLK_W'(b);
         end
      end
   end

   assign decide   = probe_valid_i && !decided_q && (any_hit || probe_last_i);
   assign pa_raddr = {set_i, off_q, win_blk};

   tlb_ram #(
      .AW (`TLB_PA_AW),
      .DW (`TLB_VPN_W)
   ) u_pa_ram (
      .clk_i    (clk_i),
      .we_i     (pa_we_i),
      .waddr_i  (pa_waddr_i),
      .wdata_i  (pa_wdata_i),
      .raddr0_i (pa_raddr),
      .raddr1_i ('0),
      .rdata0_o (pa_rdata),
      .rdata1_o ()
   );

   ////////////////////////////////////////////////////////////
   // Outcome pipeline, PA read stage then output stage
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         decided_q  <= 1'b0;
         hit_wait_q <= 1'b0;
         pend_q     <= '0;
         result_o   <= '0;
      end else begin
         if (release_o) begin
            decided_q <= 1'b0;
         end else if (decide) begin
            decided_q <= 1'b1;
         end
         if (release_o) begin
            hit_wait_q <= 1'b0;
         end else if (result_o.hit) begin
            hit_wait_q <= 1'b1;                      // Hold until translation is sent
         end
         pend_q      <= '0;
         pend_q.hit  <= decide && any_hit && !win_prot;
         pend_q.miss <= decide && !any_hit;
         pend_q.prot <= decide && any_hit && win_prot;
         result_o    <= pend_q;
      end
   end

   // Page offset stays put until the next accepted request
   always_ff @(posedge clk_i) begin
      if (pend_q.hit) begin
         paddr_o <= {pa_rdata, page_off_i};
      end
   end

   assign stop_o    = result_o.hit | result_o.miss | result_o.prot;
   assign release_o = result_o.miss | result_o.prot | (trans_sent_i && hit_wait_q);

endmodule

/* logic/tlb_search_ctrl.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_search_ctrl (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  tlb_pkg::lookup_req_t    req_i,
   input  logic                    stop_i,
   input  logic                    release_i,
   output logic [`TLB_ADDR_W-1:0]  vaddr_o,
   output logic                    is_write_o,
   output logic [`TLB_SET_W-1:0]   set_o,
   output logic [`TLB_OFF_W-1:0]   off_o,
   output logic                    probe_valid_o,
   output logic                    probe_last_o,
   output logic                    busy_o
);

   localparam logic [`TLB_OFF_W-1:0] LAST_OFF = `TLB_OFF_W'(`TLB_OFFSETS - 1);

   tlb_pkg::ctrl_state_e    state_q;
   tlb_pkg::ctrl_state_e    state_d;
   logic                    accept;
   logic                    issue_q;   // A probe goes out this cycle
   logic [`TLB_OFF_W-1:0]   off_q;
   logic                    pv_q;
   logic                    last_q;
   logic [`TLB_ADDR_W-1:0]  vaddr_q;
   logic                    is_write_q;

   assign accept = (state_q == tlb_pkg::IDLE) && req_i.valid;

   ////////////////////////////////////////////////////////////
   // Lookup FSM
   ////////////////////////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         tlb_pkg::IDLE: begin
            if (accept) begin
               state_d = tlb_pkg::SEARCH;
            end
         end
         tlb_pkg::SEARCH: begin
            // Miss and prot release together with stop
            if (release_i) begin
               state_d = tlb_pkg::IDLE;
            end else if (stop_i) begin
               state_d = tlb_pkg::WAIT;
            end
         end
         tlb_pkg::WAIT: begin
            if (release_i) begin
               state_d = tlb_pkg::IDLE;
            end
         end
         default: state_d = tlb_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= tlb_pkg::IDLE;
         issue_q <= 1'b0;
         off_q   <= '0;
         pv_q    <= 1'b0;
         last_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         pv_q    <= issue_q;                         // Block read latency
         last_q  <= issue_q && (off_q == LAST_OFF);
         if (accept) begin
            issue_q <= 1'b1;
            off_q   <= '0;                           // Always start at offset 0
         end else if (stop_i) begin
            issue_q <= 1'b0;
         end else if (issue_q) begin
            off_q <= off_q + 1'b1;
            if (off_q == LAST_OFF) begin
               issue_q <= 1'b0;
            end
         end
      end
   end

   // Request capture
   always_ff @(posedge clk_i) begin
      if (accept) begin
         vaddr_q    <= req_i.vaddr;
         is_write_q <= req_i.is_write;
      end
   end

   assign vaddr_o    = vaddr_q;
   assign is_write_o = is_write_q;
   assign set_o      = vaddr_q[`TLB_PAGE_W +: `TLB_SET_W];
   assign off_o      = off_q;

   // Late probe results are dropped once the search is left
   assign probe_valid_o = pv_q && (state_q == tlb_pkg::SEARCH);
   assign probe_last_o  = last_q && (state_q == tlb_pkg::SEARCH);

   assign busy_o = (state_q != tlb_pkg::IDLE);

endmodule

/* logic/tlb_va_block.sv */
`timescale 1ns/100ps
`include "tlb_cfg.svh"

module tlb_va_block (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   we_i,
   input  logic [`TLB_VA_AW-1:0]  waddr_i,
   input  tlb_pkg::tlb_entry_t    wdata_i,
   input  logic [`TLB_SET_W-1:0]  set_i,
   input  logic [`TLB_OFF_W-1:0]  off_i,
   input  logic [`TLB_VPN_W-1:0]  vpn_i,
   input  logic                   is_write_i,
   output tlb_pkg::probe_t        probe_o
);

   localparam int unsigned SLOTS = `TLB_SETS * `TLB_OFFSETS;

   logic [SLOTS-1:0]                      valid_q;
   logic                                  valid_rd_q;
   logic                                  is_write_q;
   logic [`TLB_SET_W+`TLB_OFF_W-1:0]      wslot;
   logic [`TLB_SET_W+`TLB_OFF_W-1:0]      rslot;
   logic                                  wr_start;
   logic [`TLB_VA_AW-1:0]                 raddr_start;
   logic [`TLB_VA_AW-1:0]                 raddr_end;
   tlb_pkg::tlb_entry_t                   start_rd;
   tlb_pkg::tlb_entry_t                   end_rd;
   logic                                  match;

   // Write address is {set, half, offset}, half clear for the start word
   assign wr_start = ~waddr_i[`TLB_OFF_W];
   assign wslot    = {waddr_i[`TLB_VA_AW-1 -: `TLB_SET_W], waddr_i[`TLB_OFF_W-1:0]};
   assign rslot    = {set_i, off_i};

   assign raddr_start = {set_i, 1'b0, off_i};
   assign raddr_end   = {set_i, 1'b1, off_i};

   tlb_ram #(
      .AW (`TLB_VA_AW),
      .DW ($bits(tlb_pkg::tlb_entry_t))
   ) u_va_ram (
      .clk_i    (clk_i),
      .we_i     (we_i),
      .waddr_i  (waddr_i),
      .wdata_i  (wdata_i),
      .raddr0_i (raddr_start),
      .raddr1_i (raddr_end),
      .rdata0_o (start_rd),
      .rdata1_o (end_rd)
   );

   ////////////////////////////////////////////////////////////
   // Slot valid bits, kept in flops so reset empties the TLB
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         valid_q <= '0;
      end else if (we_i && wr_start) begin
         valid_q[wslot] <= wdata_i.valid;
      end
   end

   // Same latency as the RAM read
   always_ff @(posedge clk_i) begin
      valid_rd_q <= valid_q[rslot];
      is_write_q <= is_write_i;
   end

   // Range check: start <= vpn <= end
   assign match = valid_rd_q && (start_rd.vpn <= vpn_i) && (vpn_i <= end_rd.vpn);

   assign probe_o.hit  = match;
   assign probe_o.prot = match && is_write_q && !start_rd.write_ok;  // Write to read-only page

endmodule

/* logic/tlb_ram.sv */
`timescale 1ns/100ps

module tlb_ram #(
   parameter int unsigned AW = 6,
   parameter int unsigned DW = 32
) (
   input  logic          clk_i,
   input  logic          we_i,
   input  logic [AW-1:0] waddr_i,
   input  logic [DW-1:0] wdata_i,
   input  logic [AW-1:0] raddr0_i,
   input  logic [AW-1:0] raddr1_i,
   output logic [DW-1:0] rdata0_o,
   output logic [DW-1:0] rdata1_o
);

   logic [DW-1:0] mem [2**AW];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      // Both reads registered, old data on a same-address write
      rdata0_o <= mem[raddr0_i];
      rdata1_o <= mem[raddr1_i];
   end

endmodule

/* logic/tlb_pkg.sv */
`include "tlb_cfg.svh"

package tlb_pkg;

   // Lookup FSM
   typedef enum logic [1:0] {
      IDLE,
      SEARCH,
      WAIT
   } ctrl_state_e;

   // One VA word, start or end of a page range
   typedef struct packed {
      logic                     valid;
      logic                     write_ok;
      logic [`TLB_SPARE_W-1:0]  spare;
      logic [`TLB_VPN_W-1:0]    vpn;
   } tlb_entry_t;

   typedef struct packed {
      logic                     valid;     // Single-cycle strobe
      logic [`TLB_ADDR_W-1:0]   vaddr;
      logic                     is_write;
   } lookup_req_t;

   typedef struct packed {
      logic                     en;
      logic [`TLB_CFG_AW-1:0]   addr;
      logic [`TLB_CFG_DW-1:0]   data;
   } cfg_wr_t;

   // Per-block compare result
   typedef struct packed {
      logic hit;
      logic prot;
   } probe_t;

   typedef struct packed {
      logic hit;
      logic miss;
      logic prot;
   } tlb_result_t;

endpackage

/* logic/tlb_cfg.svh */
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// Address geometry
`define TLB_ADDR_W        32
`define TLB_PAGE_W        12  // 4 kB pages
`define TLB_VPN_W         20

// Set, offset and block organisation
`define TLB_SETS          8
`define TLB_SET_W         3
`define TLB_OFFSETS       4
`define TLB_OFF_W         2
`define TLB_BLOCKS        4
`define TLB_BLK_W         2
`define TLB_SPARE_W       10

// RAM addressing
`define TLB_VA_AW         6   // {set, half, offset}
`define TLB_PA_AW         7   // {set, offset, block}

// Configuration write layout
`define TLB_CFG_AW        9
`define TLB_CFG_DW        31
`define TLB_CFG_PA_BIT    8   // Set selects the PA RAM
`define TLB_CFG_HALF_BIT  4   // Start or end word, spare for PA writes
`define TLB_CFG_VALID_BIT 30
`define TLB_CFG_WOK_BIT   29

`endif
